//--- design/uart_cfg.svh
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// character size on the serial line
`define UART_DATA_WIDTH 8

// system clocks per serial bit, even so the receiver has a clean mid-bit point
`define UART_CLOCKS_PER_BIT 8

// flops between the pin and the receive state machine
`define UART_SYNC_STAGES 3

// wishbone word address bits, four registers
`define UART_ADDR_WIDTH 2

`endif

//--- design/uart_frame_pkg.sv
package uart_frame_pkg;

	// run-time parity selection, code 3 behaves as none
	typedef enum logic [1:0] {
		PARITY_NONE = 2'd0,
		PARITY_EVEN = 2'd1,
		PARITY_ODD  = 2'd2
	} parity_mode_e;

	typedef enum logic [2:0] {
		TX_IDLE   = 3'd0,       // waiting for a load
		TX_WAIT   = 3'd1,       // byte held, waiting for the first tick
		TX_START  = 3'd2,       // start bit on the line
		TX_DATA   = 3'd3,       // data bits, lsb first
		TX_PARITY = 3'd4,
		TX_STOP   = 3'd5
	} tx_state_e;

	typedef enum logic [2:0] {
		RX_IDLE   = 3'd0,       // line high, looking for a falling edge
		RX_START  = 3'd1,       // half-bit wait, start bit re-check
		RX_DATA   = 3'd2,
		RX_PARITY = 3'd3,
		RX_STOP   = 3'd4
	} rx_state_e;

endpackage

//--- design/uart_bus_pkg.sv
`include "uart_cfg.svh"

package uart_bus_pkg;

	// word addresses on the wishbone side
	typedef enum logic [`UART_ADDR_WIDTH-1:0] {
		REG_DATA   = 2'd0,      // rx byte on read, tx byte on write
		REG_STATUS = 2'd1,      // flags, write ones to clear errors
		REG_CTRL   = 2'd2,      // parity mode in bits 1:0
		REG_NONE   = 2'd3       // reads zero
	} reg_addr_e;

	// bit positions inside STATUS
	typedef enum int unsigned {
		ST_TX_BUSY    = 0,
		ST_RX_VALID   = 1,
		ST_PARITY_ERR = 2,
		ST_OVERRUN    = 3,
		ST_FRAME_ERR  = 4
	} status_bit_e;

endpackage

//--- design/uart_baud_gen.sv
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_baud_gen (
	input  logic clk,
	input  logic reset,
	output logic o_bit_tick
);

	localparam int CNT_W = $clog2(`UART_CLOCKS_PER_BIT);

	logic [CNT_W-1:0] div_cnt;      // position inside the current bit period
	logic             wrap;

	assign wrap       = (div_cnt == CNT_W'(`UART_CLOCKS_PER_BIT - 1));
	assign o_bit_tick = wrap;       // one clock wide, once per bit period

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt <= '0;
		end else if (wrap) begin
			div_cnt <= '0;          // free running, never stalls
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

endmodule

//--- design/uart_tx.sv
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_tx (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          i_bit_tick,
	input  logic                          i_load,
	input  logic [`UART_DATA_WIDTH-1:0]   i_data,
	input  uart_frame_pkg::parity_mode_e  i_parity_mode,
	output logic                          o_busy,
	output logic                          o_serial
);

	localparam int BIT_CNT_W = $clog2(`UART_DATA_WIDTH);

	uart_frame_pkg::tx_state_e    state;
	logic [`UART_DATA_WIDTH-1:0]  shift_q;      // next data bit sits in bit 0
	logic [BIT_CNT_W-1:0]         bit_cnt;      // data bit currently on the line
	logic                         parity_en;    // frame carries a parity bit
	logic                         parity_bit;   // computed once at load
	logic                         take_load;
	logic                         last_data;

	assign take_load = i_load && (state == uart_frame_pkg::TX_IDLE);    // load ignored while busy
	assign last_data = (bit_cnt == BIT_CNT_W'(`UART_DATA_WIDTH - 1));
	assign o_busy    = (state != uart_frame_pkg::TX_IDLE);              // set the cycle after load

	// byte and parity bit, captured at load and shifted out on ticks
	always_ff @(posedge clk) begin
		if (take_load) begin
			shift_q    <= i_data;
			parity_en  <= (i_parity_mode == uart_frame_pkg::PARITY_EVEN) ||
			              (i_parity_mode == uart_frame_pkg::PARITY_ODD);
			parity_bit <= (i_parity_mode == uart_frame_pkg::PARITY_ODD) ? ~^i_data : ^i_data;
		end else if (i_bit_tick && (state == uart_frame_pkg::TX_START ||
		                            state == uart_frame_pkg::TX_DATA)) begin
			shift_q <= shift_q >> 1;                // bit 0 just went to the line
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= uart_frame_pkg::TX_IDLE;
			o_serial <= 1'b1;                       // line idles high
			bit_cnt  <= '0;
		end else begin
			case (state)
				uart_frame_pkg::TX_IDLE: begin
					if (take_load) begin
						state <= uart_frame_pkg::TX_WAIT;
					end
				end
				uart_frame_pkg::TX_WAIT: begin
					if (i_bit_tick) begin
						o_serial <= 1'b0;           // start bit
						state    <= uart_frame_pkg::TX_START;
					end
				end
				uart_frame_pkg::TX_START: begin
					if (i_bit_tick) begin
						o_serial <= shift_q[0];     // lsb first
						bit_cnt  <= '0;
						state    <= uart_frame_pkg::TX_DATA;
					end
				end
				uart_frame_pkg::TX_DATA: begin
					if (i_bit_tick) begin
						if (last_data) begin
							if (parity_en) begin
								o_serial <= parity_bit;
								state    <= uart_frame_pkg::TX_PARITY;
							end else begin
								o_serial <= 1'b1;   // stop bit
								state    <= uart_frame_pkg::TX_STOP;
							end
						end else begin
							o_serial <= shift_q[0];
							bit_cnt  <= bit_cnt + 1'b1;
						end
					end
				end
				uart_frame_pkg::TX_PARITY: begin
					if (i_bit_tick) begin
						o_serial <= 1'b1;
						state    <= uart_frame_pkg::TX_STOP;
					end
				end
				uart_frame_pkg::TX_STOP: begin
					if (i_bit_tick) begin
						state <= uart_frame_pkg::TX_IDLE;   // busy drops at end of stop bit
					end
				end
				default: begin
					o_serial <= 1'b1;
					state    <= uart_frame_pkg::TX_IDLE;
				end
			endcase
		end
	end

endmodule

//--- design/uart_rx.sv
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_rx (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          i_serial,
	input  uart_frame_pkg::parity_mode_e  i_parity_mode,
	output logic                          o_strobe,
	output logic [`UART_DATA_WIDTH-1:0]   o_data,
	output logic                          o_parity_err,
	output logic                          o_frame_err
);

	localparam int CNT_W     = $clog2(`UART_CLOCKS_PER_BIT);
	localparam int BIT_CNT_W = $clog2(`UART_DATA_WIDTH);
	localparam int HALF_BIT  = `UART_CLOCKS_PER_BIT / 2;

	logic [`UART_SYNC_STAGES-1:0] sync_q;       // pin enters at bit 0
	logic                         line;         // synchronized serial input
	logic                         line_prev;    // for falling edge detect
	logic                         fall;
	uart_frame_pkg::rx_state_e    state;
	logic [CNT_W-1:0]             clk_cnt;      // clocks since the last sample point
	logic [BIT_CNT_W-1:0]         bit_cnt;
	logic                         half_point;
	logic                         bit_point;
	logic                         start_ok;
	logic [`UART_DATA_WIDTH-1:0]  shift_q;
	logic                         parity_acc;   // xor of the data bits seen so far
	logic                         parity_en;
	logic                         parity_odd;
	logic                         parity_err_q;

	assign line       = sync_q[`UART_SYNC_STAGES-1];
	assign fall       = line_prev && !line;
	assign half_point = (clk_cnt == CNT_W'(HALF_BIT - 1));
	assign bit_point  = (clk_cnt == CNT_W'(`UART_CLOCKS_PER_BIT - 1));
	assign start_ok   = (state == uart_frame_pkg::RX_START) && half_point && !line;

	always_ff @(posedge clk) begin
		if (reset) begin
			sync_q    <= '1;                        // idle line level
			line_prev <= 1'b1;
		end else begin
			sync_q    <= {sync_q[`UART_SYNC_STAGES-2:0], i_serial};
			line_prev <= line;
		end
	end

	// data path, parity and result capture
	always_ff @(posedge clk) begin
		if (start_ok) begin
			parity_acc   <= 1'b0;
			parity_err_q <= 1'b0;                   // stays clear in frames without parity
			parity_en    <= (i_parity_mode == uart_frame_pkg::PARITY_EVEN) ||
			                (i_parity_mode == uart_frame_pkg::PARITY_ODD);
			parity_odd   <= (i_parity_mode == uart_frame_pkg::PARITY_ODD);
		end
		if (state == uart_frame_pkg::RX_DATA && bit_point) begin
			shift_q    <= {line, shift_q[`UART_DATA_WIDTH-1:1]};  // lsb arrives first
			parity_acc <= parity_acc ^ line;
		end
		if (state == uart_frame_pkg::RX_PARITY && bit_point) begin
			parity_err_q <= ((parity_acc ^ line) != parity_odd);
		end
		if (state == uart_frame_pkg::RX_STOP && bit_point) begin
			o_data       <= shift_q;
			o_parity_err <= parity_err_q;
			o_frame_err  <= !line;                  // stop bit must be high
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= uart_frame_pkg::RX_IDLE;
			clk_cnt  <= '0;
			bit_cnt  <= '0;
			o_strobe <= 1'b0;
		end else begin
			o_strobe <= 1'b0;
			clk_cnt  <= clk_cnt + 1'b1;
			case (state)
				uart_frame_pkg::RX_IDLE: begin
					clk_cnt <= '0;
					if (fall) begin
						state <= uart_frame_pkg::RX_START;
					end
				end
				uart_frame_pkg::RX_START: begin
					if (half_point) begin
						clk_cnt <= '0;
						bit_cnt <= '0;
						// high at mid-bit means a glitch, not a start bit
						state   <= line ? uart_frame_pkg::RX_IDLE : uart_frame_pkg::RX_DATA;
					end
				end
				uart_frame_pkg::RX_DATA: begin
					if (bit_point) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == BIT_CNT_W'(`UART_DATA_WIDTH - 1)) begin
							state <= parity_en ? uart_frame_pkg::RX_PARITY
							                   : uart_frame_pkg::RX_STOP;
						end
					end
				end
				uart_frame_pkg::RX_PARITY: begin
					if (bit_point) begin
						state <= uart_frame_pkg::RX_STOP;
					end
				end
				uart_frame_pkg::RX_STOP: begin
					if (bit_point) begin
						o_strobe <= 1'b1;           // result valid with this pulse
						state    <= uart_frame_pkg::RX_IDLE;
					end
				end
				default: state <= uart_frame_pkg::RX_IDLE;
			endcase
		end
	end

endmodule

//--- design/uart_wb_regs.sv
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_wb_regs (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          i_wb_cyc,
	input  logic                          i_wb_stb,
	input  logic                          i_wb_we,
	input  logic [`UART_ADDR_WIDTH-1:0]   i_wb_adr,
	input  logic [7:0]                    i_wb_dat,
	input  logic                          i_tx_busy,
	input  logic                          i_rx_strobe,
	input  logic [`UART_DATA_WIDTH-1:0]   i_rx_data,
	input  logic                          i_rx_parity_err,
	input  logic                          i_rx_frame_err,
	output logic [7:0]                    o_wb_dat,
	output logic                          o_wb_ack,
	output logic                          o_tx_load,
	output logic [`UART_DATA_WIDTH-1:0]   o_tx_data,
	output uart_frame_pkg::parity_mode_e  o_parity_mode
);

	uart_bus_pkg::reg_addr_e      addr;
	logic                         req;          // one cycle per access
	logic                         wr;
	logic                         rd;
	logic                         data_rd;
	logic                         status_wr;
	logic [`UART_DATA_WIDTH-1:0]  rx_data_q;
	logic                         rx_valid;
	logic                         parity_err;   // sticky
	logic                         frame_err;    // sticky
	logic                         overrun;      // sticky
	logic [7:0]                   status;

	assign addr      = uart_bus_pkg::reg_addr_e'(i_wb_adr);
	assign req       = i_wb_cyc && i_wb_stb && !o_wb_ack;  // no second effect on the ack cycle
	assign wr        = req && i_wb_we;
	assign rd        = req && !i_wb_we;
	assign data_rd   = rd && (addr == uart_bus_pkg::REG_DATA);
	assign status_wr = wr && (addr == uart_bus_pkg::REG_STATUS);

	always_comb begin
		status = '0;
		status[uart_bus_pkg::ST_TX_BUSY]    = i_tx_busy;
		status[uart_bus_pkg::ST_RX_VALID]   = rx_valid;
		status[uart_bus_pkg::ST_PARITY_ERR] = parity_err;
		status[uart_bus_pkg::ST_OVERRUN]    = overrun;
		status[uart_bus_pkg::ST_FRAME_ERR]  = frame_err;
	end

	// read data and the tx byte
	always_ff @(posedge clk) begin
		if (i_rx_strobe) begin
			rx_data_q <= i_rx_data;                 // newest byte always wins
		end
		if (wr && addr == uart_bus_pkg::REG_DATA) begin
			o_tx_data <= i_wb_dat[`UART_DATA_WIDTH-1:0];
		end
		if (rd) begin
			case (addr)
				uart_bus_pkg::REG_DATA:   o_wb_dat <= 8'(rx_data_q);
				uart_bus_pkg::REG_STATUS: o_wb_dat <= status;
				uart_bus_pkg::REG_CTRL:   o_wb_dat <= {6'd0, o_parity_mode};
				default:                  o_wb_dat <= 8'd0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			o_wb_ack      <= 1'b0;
			o_tx_load     <= 1'b0;
			o_parity_mode <= uart_frame_pkg::PARITY_NONE;
			rx_valid      <= 1'b0;
			parity_err    <= 1'b0;
			frame_err     <= 1'b0;
			overrun       <= 1'b0;
		end else begin
			o_wb_ack <= req;
			// a write while busy is acked and dropped
			o_tx_load <= wr && (addr == uart_bus_pkg::REG_DATA) && !i_tx_busy;
			if (wr && addr == uart_bus_pkg::REG_CTRL) begin
				o_parity_mode <= uart_frame_pkg::parity_mode_e'(i_wb_dat[1:0]);
			end

			if (data_rd) begin
				rx_valid <= 1'b0;
			end
			if (status_wr) begin                    // write one to clear
				if (i_wb_dat[uart_bus_pkg::ST_PARITY_ERR]) parity_err <= 1'b0;
				if (i_wb_dat[uart_bus_pkg::ST_FRAME_ERR])  frame_err  <= 1'b0;
				if (i_wb_dat[uart_bus_pkg::ST_OVERRUN])    overrun    <= 1'b0;
			end

			// a new byte takes priority over a clear in the same cycle
			if (i_rx_strobe) begin
				rx_valid <= 1'b1;
				if (rx_valid && !data_rd) begin
					overrun <= 1'b1;                // previous byte never read
				end
				if (i_rx_parity_err) begin
					parity_err <= 1'b1;
				end
				if (i_rx_frame_err) begin
					frame_err <= 1'b1;
				end
			end
		end
	end

endmodule

//--- design/uart_top.sv
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_top (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         i_wb_cyc,
	input  logic                         i_wb_stb,
	input  logic                         i_wb_we,
	input  logic [`UART_ADDR_WIDTH-1:0]  i_wb_adr,
	input  logic [7:0]                   i_wb_dat,
	output logic [7:0]                   o_wb_dat,
	output logic                         o_wb_ack,
	output logic                         o_serial,
	input  logic                         i_serial        // asynchronous to clk
);

	logic                          tx_load;
	logic [`UART_DATA_WIDTH-1:0]   tx_data;
	logic                          tx_busy;
	logic                          bit_tick;
	logic                          rx_strobe;
	logic [`UART_DATA_WIDTH-1:0]   rx_data;
	logic                          rx_parity_err;
	logic                          rx_frame_err;
	uart_frame_pkg::parity_mode_e  parity_mode;      // shared by tx and rx

	uart_wb_regs u_regs (
		.clk             (clk),
		.reset           (reset),
		.i_wb_cyc        (i_wb_cyc),
		.i_wb_stb        (i_wb_stb),
		.i_wb_we         (i_wb_we),
		.i_wb_adr        (i_wb_adr),
		.i_wb_dat        (i_wb_dat),
		.i_tx_busy       (tx_busy),
		.i_rx_strobe     (rx_strobe),
		.i_rx_data       (rx_data),
		.i_rx_parity_err (rx_parity_err),
		.i_rx_frame_err  (rx_frame_err),
		.o_wb_dat        (o_wb_dat),
		.o_wb_ack        (o_wb_ack),
		.o_tx_load       (tx_load),
		.o_tx_data       (tx_data),
		.o_parity_mode   (parity_mode)
	);

	uart_baud_gen u_baud (
		.clk        (clk),
		.reset      (reset),
		.o_bit_tick (bit_tick)
	);

	uart_tx u_tx (
		.clk           (clk),
		.reset         (reset),
		.i_bit_tick    (bit_tick),
		.i_load        (tx_load),
		.i_data        (tx_data),
		.i_parity_mode (parity_mode),
		.o_busy        (tx_busy),
		.o_serial      (o_serial)
	);

	uart_rx u_rx (
		.clk           (clk),
		.reset         (reset),
		.i_serial      (i_serial),
		.i_parity_mode (parity_mode),
		.o_strobe      (rx_strobe),
		.o_data        (rx_data),
		.o_parity_err  (rx_parity_err),
		.o_frame_err   (rx_frame_err)
	);

endmodule

//--- tests/uart_tb.sv
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_tb;

	localparam int CPB        = `UART_CLOCKS_PER_BIT;
	localparam int ACK_LIMIT  = 20;             // clocks before a bus access is abandoned
	localparam int POLL_LIMIT = 400;            // status reads before a wait gives up
	localparam logic [7:0] BUSY_M    = 8'h01;
	localparam logic [7:0] VALID_M   = 8'h02;
	localparam logic [7:0] PAR_M     = 8'h04;
	localparam logic [7:0] OVR_M     = 8'h08;
	localparam logic [7:0] FRAME_M   = 8'h10;
	localparam logic [7:0] ERRORS_M  = 8'h1C;

	logic                        clk;
	logic                        reset;
	logic                        wb_cyc;
	logic                        wb_stb;
	logic                        wb_we;
	logic [`UART_ADDR_WIDTH-1:0] wb_adr;
	logic [7:0]                  wb_dat_w;
	logic [7:0]                  wb_dat_r;
	logic                        wb_ack;
	logic                        serial_out;
	logic                        serial_in;
	logic                        loopback;      // rx fed straight from tx
	logic                        line_drv;      // bit-banged serial line
	integer                      seed;
	int                          errors;
	int                          checks;
	int                          timeouts;
	logic [7:0]                  rd_val;
	logic [7:0]                  st;
	logic [7:0]                  byte_a;
	logic [7:0]                  byte_b;

	assign serial_in = loopback ? serial_out : line_drv;

	uart_top UUT (
		.clk      (clk),
		.reset    (reset),
		.i_wb_cyc (wb_cyc),
		.i_wb_stb (wb_stb),
		.i_wb_we  (wb_we),
		.i_wb_adr (wb_adr),
		.i_wb_dat (wb_dat_w),
		.o_wb_dat (wb_dat_r),
		.o_wb_ack (wb_ack),
		.o_serial (serial_out),
		.i_serial (serial_in)
	);

	always #50 clk = ~clk;                      // 100 ns period

	task automatic expect_value(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAILED %s: got 0x%02h expected 0x%02h", name, got, exp);
		end
	endtask

	// one classic cycle, request held until ack
	task automatic bus_access(input logic we, input logic [`UART_ADDR_WIDTH-1:0] adr,
	                          input logic [7:0] wdat, output logic [7:0] rdat);
		int n;
		@(negedge clk);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdat;
		n = 0;
		while (!wb_ack && n < ACK_LIMIT) begin
			@(negedge clk);
			n++;
		end
		rdat = wb_dat_r;                        // registered with ack
		if (!wb_ack) begin
			timeouts++;
			$display("timeout: no bus acknowledge at address %0d", adr);
		end else begin
			expect_value("wb_ack latency", 8'(n), 8'h01);
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic write_reg(input logic [`UART_ADDR_WIDTH-1:0] adr, input logic [7:0] wdat);
		logic [7:0] unused_rd;
		bus_access(1'b1, adr, wdat, unused_rd);
	endtask

	task automatic read_reg(input logic [`UART_ADDR_WIDTH-1:0] adr, output logic [7:0] rdat);
		bus_access(1'b0, adr, 8'h00, rdat);
	endtask

	// poll STATUS until any bit of mask is set
	task automatic wait_status(input logic [7:0] mask, input string what, output logic [7:0] sv);
		int n;
		n = 0;
		sv = 8'h00;
		while ((sv & mask) == 8'h00 && n < POLL_LIMIT) begin
			read_reg(uart_bus_pkg::REG_STATUS, sv);
			n++;
		end
		if ((sv & mask) == 8'h00) begin
			timeouts++;
			$display("timeout: %s never came up in STATUS", what);
		end
	endtask

	// start bit must be low at its centre
	task automatic watch_start_bit();
		int n;
		n = 0;
		while (serial_out && n < 4 * CPB) begin
			@(negedge clk);
			n++;
		end
		if (serial_out) begin
			timeouts++;
			$display("timeout: no start bit on the serial output after a DATA write");
		end else begin
			repeat (CPB / 2) @(negedge clk);
			expect_value("o_serial start bit", 8'(serial_out), 8'h00);
		end
	endtask

	task automatic loopback_byte(input logic [7:0] data);
		logic [7:0] sv;
		logic [7:0] got;
		write_reg(uart_bus_pkg::REG_DATA, data);
		watch_start_bit();
		read_reg(uart_bus_pkg::REG_STATUS, sv);
		expect_value("status tx_busy", sv & BUSY_M, BUSY_M);     // still inside the frame
		wait_status(VALID_M, "rx_valid", sv);
		read_reg(uart_bus_pkg::REG_DATA, got);
		expect_value("rx data", got, data);
		expect_value("status error bits", sv & ERRORS_M, 8'h00);
	endtask

	task automatic drive_bit(input logic b);
		line_drv = b;
		repeat (CPB) @(negedge clk);
	endtask

	// even parity frame, lsb first, parity and stop level chosen by caller
	task automatic send_frame(input logic [7:0] data, input logic par, input logic stop);
		@(negedge clk);
		loopback = 1'b0;
		drive_bit(1'b0);
		for (int i = 0; i < 8; i++) begin
			drive_bit(data[i]);
		end
		drive_bit(par);
		drive_bit(stop);
		drive_bit(1'b1);                        // idle gap
		drive_bit(1'b1);
	endtask

	initial begin
		repeat (100000) @(posedge clk);
		$display("simulation did not finish within 100000 clock cycles");
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		clk      = 1'b0;
		reset    = 1'b1;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = 8'h00;
		loopback = 1'b1;
		line_drv = 1'b1;
		seed     = 32'h39a8;
		errors   = 0;
		checks   = 0;
		timeouts = 0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// state out of reset
		expect_value("o_serial idle", 8'(serial_out), 8'h01);
		read_reg(uart_bus_pkg::REG_STATUS, rd_val);
		expect_value("status after reset", rd_val, 8'h00);
		read_reg(uart_bus_pkg::REG_CTRL, rd_val);
		expect_value("ctrl after reset", rd_val, 8'h00);

		// loopback under none, even and odd parity
		for (int mode = 0; mode < 3; mode++) begin
			write_reg(uart_bus_pkg::REG_CTRL, 8'(mode));
			read_reg(uart_bus_pkg::REG_CTRL, rd_val);
			expect_value("ctrl parity mode", rd_val, 8'(mode));
			repeat (20) begin
				byte_a = 8'($random(seed));
				loopback_byte(byte_a);
			end
		end

		// wrong parity bit, then low stop bit
		write_reg(uart_bus_pkg::REG_CTRL, 8'h01);
		byte_a = 8'($random(seed));
		send_frame(byte_a, ~(^byte_a), 1'b1);
		wait_status(VALID_M, "rx_valid after bad parity", st);
		expect_value("status parity_error", st & PAR_M, PAR_M);
		read_reg(uart_bus_pkg::REG_DATA, rd_val);
		expect_value("rx data with bad parity", rd_val, byte_a);
		byte_b = 8'($random(seed));
		send_frame(byte_b, ^byte_b, 1'b0);
		wait_status(VALID_M, "rx_valid after low stop bit", st);
		expect_value("status framing_error", st & FRAME_M, FRAME_M);
		read_reg(uart_bus_pkg::REG_DATA, rd_val);
		write_reg(uart_bus_pkg::REG_STATUS, 8'hFF);      // clear every sticky flag
		read_reg(uart_bus_pkg::REG_STATUS, rd_val);
		expect_value("status errors after clear", rd_val & ERRORS_M, 8'h00);

		// second write while busy is dropped
		loopback = 1'b1;
		write_reg(uart_bus_pkg::REG_CTRL, 8'h00);
		byte_a = 8'($random(seed));
		byte_b = ~byte_a;
		write_reg(uart_bus_pkg::REG_DATA, byte_a);
		write_reg(uart_bus_pkg::REG_DATA, byte_b);
		wait_status(VALID_M, "rx_valid after back-to-back writes", st);
		read_reg(uart_bus_pkg::REG_DATA, rd_val);
		expect_value("rx data first write", rd_val, byte_a);
		repeat (12 * CPB) @(negedge clk);       // room for a second frame that must not come
		read_reg(uart_bus_pkg::REG_STATUS, rd_val);
		expect_value("status after dropped write", rd_val & (VALID_M | BUSY_M), 8'h00);

		// two frames, no DATA read between them
		byte_a = 8'($random(seed));
		byte_b = 8'($random(seed));
		write_reg(uart_bus_pkg::REG_DATA, byte_a);
		wait_status(VALID_M, "rx_valid for first unread byte", st);
		write_reg(uart_bus_pkg::REG_DATA, byte_b);
		wait_status(OVR_M, "overrun", st);
		expect_value("status rx_valid with overrun", st & VALID_M, VALID_M);
		read_reg(uart_bus_pkg::REG_DATA, rd_val);
		expect_value("rx data after overrun", rd_val, byte_b);
		write_reg(uart_bus_pkg::REG_STATUS, OVR_M);
		read_reg(uart_bus_pkg::REG_STATUS, rd_val);
		expect_value("status after overrun clear", rd_val, 8'h00);

		$display("checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

//--- sources.f
+incdir+design
design/uart_frame_pkg.sv
design/uart_bus_pkg.sv
design/uart_baud_gen.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_wb_regs.sv
design/uart_top.sv
tests/uart_tb.sv

//--- Makefile
VERILATOR  = verilator
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = uart_tb
FILELIST   = sources.f
BUILD_DIR  = obj_dir
LOG        = sim.log
FAIL_MSG   = *** FAILED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -F -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
